//--- Bender.yml
package:
  name: pcg_fetch

sources:
  - logic/pcg_pkg.sv
  - logic/pcg_ctrl_fsm.sv
  - logic/pcg_pc_gen.sv
  - logic/pcg_if_id_reg.sv
  - logic/pcg_pc_check.sv
  - logic/pcg_alarm_counter.sv
  - logic/pcg_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/pcg_pc_check_assert.sv
      - test/tb_pcg_checker.sv
      - test/tb_pcg_top.sv

//--- build.f
logic/pcg_pkg.sv
logic/pcg_ctrl_fsm.sv
logic/pcg_pc_gen.sv
logic/pcg_if_id_reg.sv
logic/pcg_pc_check.sv
logic/pcg_alarm_counter.sv
logic/pcg_top.sv
test/tb_clk_gen.sv
test/pcg_pc_check_assert.sv
test/tb_pcg_checker.sv
test/tb_pcg_top.sv

//--- logic/pcg_alarm_counter.sv
`timescale 1ns/1ps

module pcg_alarm_counter (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               pc_err_i,
  output logic [pcg_pkg::PCG_ERR_CNT_W-1:0] err_count_o,
  output logic                               alarm_o
);
  import pcg_pkg::*;

  logic [PCG_ERR_CNT_W-1:0] count_q;
  logic [PCG_ERR_CNT_W-1:0] count_d;
  logic                     alarm_q;

  // Hold at all ones
  assign count_d = (pc_err_i && !(&count_q)) ? count_q + 1'b1 : count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      alarm_q <= 1'b0;
    end else begin
      count_q <= count_d;
      // Sticky once the threshold is reached
      if (count_d >= PCG_ALARM_THRESHOLD) begin
        alarm_q <= 1'b1;
      end
    end
  end

  assign err_count_o = count_q;
  assign alarm_o     = alarm_q;

endmodule

//--- logic/pcg_ctrl_fsm.sv
`timescale 1ns/1ps

module pcg_ctrl_fsm (
  input  logic                clk,
  input  logic                rst_n,
  input  pcg_pkg::pcg_event_t event_i,
  input  logic                halt_i,
  input  logic                alarm_i,
  output pcg_pkg::pcg_ctrl_t  ctrl_o
);
  import pcg_pkg::*;

  pcg_state_e state_q;
  pcg_state_e state_d;

  // Any control flow request this cycle
  logic event_any;

  assign event_any = event_i.trap | event_i.mret | event_i.branch | event_i.jump;

  ////////////////////////////////////////
  // State register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////

  always_comb begin
    // Idle outputs, also used by HALT and LOCK
    state_d         = state_q;
    ctrl_o.pc_set   = 1'b0;
    ctrl_o.pc_mux   = PC_BOOT;
    ctrl_o.fetch_en = 1'b0;

    case (state_q)
      // One quiet cycle after reset release
      ST_RESET: begin
        state_d = ST_BOOT;
      end
      // Load the boot address once
      ST_BOOT: begin
        ctrl_o.pc_set = 1'b1;
        ctrl_o.pc_mux = PC_BOOT;
        state_d       = ST_RUN;
      end
      ST_RUN: begin
        if (event_any) begin
          // Priority trap > mret > branch > jump, no register in the path
          ctrl_o.pc_set = 1'b1;
          if (event_i.trap) begin
            ctrl_o.pc_mux = PC_TRAP;
          end else if (event_i.mret) begin
            ctrl_o.pc_mux = PC_MRET;
          end else if (event_i.branch) begin
            ctrl_o.pc_mux = PC_BRANCH;
          end else begin
            ctrl_o.pc_mux = PC_JUMP;
          end
        end else begin
          // Sequential fetch, halt takes effect from the next cycle
          ctrl_o.fetch_en = 1'b1;
          if (halt_i) begin
            state_d = ST_HALT;
          end
        end
      end
      // Frozen until halt is dropped
      ST_HALT: begin
        if (!halt_i) begin
          state_d = ST_RUN;
        end
      end
      // Only reset leaves LOCK
      ST_LOCK: begin
        state_d = ST_LOCK;
      end
      default: begin
        state_d = ST_RESET;
      end
    endcase

    // Fault alarm overrides every transition
    if (alarm_i) begin
      state_d = ST_LOCK;
    end
  end

endmodule

//--- logic/pcg_if_id_reg.sv
`timescale 1ns/1ps

module pcg_if_id_reg (
  input  logic                clk,
  input  logic                rst_n,
  input  pcg_pkg::pcg_ctrl_t  ctrl_i,
  input  pcg_pkg::pcg_addr_t  pc_if_i,
  input  logic                compressed_i,
  output pcg_pkg::pcg_if_id_t if_id_o
);
  import pcg_pkg::*;

  pcg_if_id_t if_id_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_q <= '0;
    end else begin
      // Any PC set kills the entry
      if (ctrl_i.pc_set) begin
        if_id_q.valid <= 1'b0;
      end else if (ctrl_i.fetch_en) begin
        if_id_q.valid <= 1'b1;
      end
      // Payload of the instruction leaving fetch
      if (ctrl_i.fetch_en) begin
        if_id_q.pc         <= pc_if_i;
        if_id_q.compressed <= compressed_i;
      end
    end
  end

  assign if_id_o = if_id_q;

endmodule

//--- logic/pcg_pc_check.sv
`timescale 1ns/1ps

module pcg_pc_check (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pcg_pkg::pcg_ctrl_t    ctrl_i,
  input  pcg_pkg::pcg_addr_t    pc_if_i,
  input  pcg_pkg::pcg_if_id_t   if_id_i,
  input  pcg_pkg::pcg_targets_t targets_i,
  output logic                  pc_err_o
);
  import pcg_pkg::*;

  // PC set seen last cycle
  logic        pc_set_q;
  // Instruction moved from IF to ID last cycle
  logic        if_id_q;
  // Sticky, set by the first PC set
  logic        compare_enable_q;
  // Own copy of the mux selection
  pcg_pc_mux_e pc_mux_q;

  // Expected PC after a sequential advance
  pcg_addr_t incr_addr;
  // Expected PC after a control flow load
  pcg_addr_t ctrl_flow_addr;
  // Expected PC for this cycle
  pcg_addr_t check_addr;
  // Comparison active this cycle
  logic      check_valid;

  ////////////////////////////////////////
  // Recompute the expected PC
  ////////////////////////////////////////

  // Previous fetch PC plus its size
  assign incr_addr = if_id_i.pc + (if_id_i.compressed ? 32'd2 : 32'd4);

  // Glitched mux in the PC generator picks another target than this copy
  always_comb begin
    case (pc_mux_q)
      PC_JUMP:   ctrl_flow_addr = targets_i.jump_target;
      PC_BRANCH: ctrl_flow_addr = targets_i.branch_target;
      PC_TRAP:   ctrl_flow_addr = targets_i.mtvec;
      PC_MRET:   ctrl_flow_addr = targets_i.mepc;
      default:   ctrl_flow_addr = targets_i.boot_addr;
    endcase
  end

  assign check_addr = pc_set_q ? {ctrl_flow_addr[31:1], 1'b0} : incr_addr;

  // Sequential check needs a live IF/ID entry
  assign check_valid = pc_set_q | (if_id_q & if_id_i.valid);

  // Mismatch only counts once the PC has been loaded
  assign pc_err_o = compare_enable_q & check_valid & (check_addr != pc_if_i);

  ////////////////////////////////////////
  // Flops
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_set_q         <= 1'b0;
      if_id_q          <= 1'b0;
      compare_enable_q <= 1'b0;
      pc_mux_q         <= PC_BOOT;
    end else begin
      pc_set_q <= ctrl_i.pc_set;
      // Advance and PC set are exclusive in the controller
      if_id_q  <= ctrl_i.fetch_en & ~ctrl_i.pc_set;
      if (ctrl_i.pc_set) begin
        pc_mux_q         <= ctrl_i.pc_mux;
        compare_enable_q <= 1'b1;
      end
    end
  end

endmodule

//--- logic/pcg_pc_gen.sv
`timescale 1ns/1ps

module pcg_pc_gen (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pcg_pkg::pcg_ctrl_t    ctrl_i,
  input  pcg_pkg::pcg_targets_t targets_i,
  input  logic                  compressed_i,
  input  pcg_pkg::pcg_addr_t    fault_mask_i,
  output pcg_pkg::pcg_addr_t    pc_if_o
);
  import pcg_pkg::*;

  // Fetch stage PC
  pcg_addr_t pc_q;

  // Selected control flow target
  pcg_addr_t target_addr;

  // Next PC on sequential fetch
  pcg_addr_t seq_addr;

  // Value loaded into the PC before the fault mask
  pcg_addr_t pc_next;

  // PC register updates this cycle
  logic pc_load;

  ////////////////////////////////////////
  // Target selection
  ////////////////////////////////////////

  always_comb begin
    case (ctrl_i.pc_mux)
      PC_JUMP:   target_addr = targets_i.jump_target;
      PC_BRANCH: target_addr = targets_i.branch_target;
      PC_TRAP:   target_addr = targets_i.mtvec;
      PC_MRET:   target_addr = targets_i.mepc;
      default:   target_addr = targets_i.boot_addr;
    endcase
  end

  // Compressed instructions are 2 bytes, full size 4
  assign seq_addr = pc_q + (compressed_i ? 32'd2 : 32'd4);

  // Targets are halfword aligned
  assign pc_next = ctrl_i.pc_set ? {target_addr[31:1], 1'b0} : seq_addr;
  assign pc_load = ctrl_i.pc_set | ctrl_i.fetch_en;

  ////////////////////////////////////////
  // PC register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (pc_load) begin
      // Lab fault hook, flips PC bits on any load
      pc_q <= pc_next ^ fault_mask_i;
    end
  end

  assign pc_if_o = pc_q;

endmodule

//--- logic/pcg_pkg.sv
package pcg_pkg;

  ////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////

  // Instruction address as seen by fetch
  typedef logic [31:0] pcg_addr_t;

  // Fault count width, wide enough to saturate well past the alarm level
  localparam int unsigned PCG_ERR_CNT_W = 4;

  // Number of detected PC faults that trips the alarm
  localparam logic [PCG_ERR_CNT_W-1:0] PCG_ALARM_THRESHOLD = 4'd3;

  ////////////////////////////////////////
  // Enums
  ////////////////////////////////////////

  // Source of a non-sequential PC load
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_TRAP,
    PC_MRET
  } pcg_pc_mux_e;

  // Controller FSM states
  typedef enum logic [2:0] {
    ST_RESET,
    ST_BOOT,
    ST_RUN,
    ST_HALT,
    ST_LOCK
  } pcg_state_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Control flow requests, MSB has highest priority
  typedef struct packed {
    logic trap;
    logic mret;
    logic branch;
    logic jump;
  } pcg_event_t;

  // Command from the controller to the fetch stage
  typedef struct packed {
    logic        pc_set;
    pcg_pc_mux_e pc_mux;
    logic        fetch_en;
  } pcg_ctrl_t;

  // All possible PC targets
  typedef struct packed {
    pcg_addr_t boot_addr;
    pcg_addr_t jump_target;
    pcg_addr_t branch_target;
    pcg_addr_t mtvec;
    pcg_addr_t mepc;
  } pcg_targets_t;

  // Contents of the IF/ID pipeline register
  typedef struct packed {
    logic      valid;
    pcg_addr_t pc;
    logic      compressed;
  } pcg_if_id_t;

endpackage

//--- logic/pcg_top.sv
`timescale 1ns/1ps

module pcg_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  pcg_pkg::pcg_event_t                event_i,
  input  pcg_pkg::pcg_targets_t              targets_i,
  input  logic                               compressed_i,
  input  logic                               halt_i,
  input  pcg_pkg::pcg_addr_t                 fault_mask_i,
  output pcg_pkg::pcg_addr_t                 pc_if_o,
  output logic                               pc_err_o,
  output logic                               alarm_o,
  output logic [pcg_pkg::PCG_ERR_CNT_W-1:0] err_count_o
);
  import pcg_pkg::*;

  pcg_ctrl_t  ctrl;
  pcg_addr_t  pc_if;
  pcg_if_id_t if_id;
  logic       pc_err;
  logic       alarm;

  ////////////////////////////////////////
  // Fetch path
  ////////////////////////////////////////

  pcg_ctrl_fsm u_ctrl_fsm (
    .clk     (clk),
    .rst_n   (rst_n),
    .event_i (event_i),
    .halt_i  (halt_i),
    .alarm_i (alarm),
    .ctrl_o  (ctrl)
  );

  pcg_pc_gen u_pc_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl),
    .targets_i    (targets_i),
    .compressed_i (compressed_i),
    .fault_mask_i (fault_mask_i),
    .pc_if_o      (pc_if)
  );

  pcg_if_id_reg u_if_id_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl),
    .pc_if_i      (pc_if),
    .compressed_i (compressed_i),
    .if_id_o      (if_id)
  );

  ////////////////////////////////////////
  // Hardening
  ////////////////////////////////////////

  pcg_pc_check u_pc_check (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl_i    (ctrl),
    .pc_if_i   (pc_if),
    .if_id_i   (if_id),
    .targets_i (targets_i),
    .pc_err_o  (pc_err)
  );

  pcg_alarm_counter u_alarm_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc_err_i    (pc_err),
    .err_count_o (err_count_o),
    .alarm_o     (alarm)
  );

  assign pc_if_o  = pc_if;
  assign pc_err_o = pc_err;
  assign alarm_o  = alarm;

endmodule

//--- test/pcg_pc_check_assert.sv
`timescale 1ns/1ps

module pcg_pc_check_assert (
  input logic                clk,
  input logic                rst_n,
  input pcg_pkg::pcg_ctrl_t  ctrl_i,
  input logic                pc_err_i,
  input logic                compare_enable_i,
  input pcg_pkg::pcg_state_e state_i
);
  import pcg_pkg::*;

  // Failed assertions, summed up by the testbench top
  int unsigned fail_cnt = 0;

  // Set by the first PC set after reset
  logic seen_set_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_set_q <= 1'b0;
    end else if (ctrl_i.pc_set) begin
      seen_set_q <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  // No comparison before the PC was ever loaded
  no_err_before_set: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_set_q |-> !pc_err_i)
  else begin
    $error("pc_err_o high before the first PC set");
    fail_cnt++;
  end

  // Compare enable is sticky
  enable_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    compare_enable_i |=> compare_enable_i)
  else begin
    $error("compare enable fell while out of reset");
    fail_cnt++;
  end

  // Locked controller never redirects fetch
  no_set_in_lock: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == ST_LOCK) |-> !ctrl_i.pc_set)
  else begin
    $error("PC set issued while the controller is locked");
    fail_cnt++;
  end

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Half of the 100 ns period
  localparam int HALF_PERIOD_NS = 50;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end
  end

  // Reset low for three rising edges, released on the third
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- test/tb_pcg_checker.sv
`timescale 1ns/1ps

module tb_pcg_checker (
  input  logic                               clk,
  input  logic                               rst_n,
  // DUT inputs, fed to the reference model
  input  pcg_pkg::pcg_event_t                event_i,
  input  pcg_pkg::pcg_targets_t              targets_i,
  input  logic                               compressed_i,
  input  logic                               halt_i,
  input  pcg_pkg::pcg_addr_t                 fault_mask_i,
  // DUT outputs
  input  pcg_pkg::pcg_addr_t                 pc_if_i,
  input  logic                               pc_err_i,
  input  logic                               alarm_i,
  input  logic [pcg_pkg::PCG_ERR_CNT_W-1:0] err_count_i,
  // Table expectations, valid for the cycle after the row
  input  logic                               row_valid_i,
  input  logic                               exp_pc_err_i,
  input  logic                               exp_alarm_i,
  output int unsigned                        pc_if_errs_o,
  output int unsigned                        pc_err_errs_o,
  output int unsigned                        alarm_errs_o,
  output int unsigned                        count_errs_o
);
  import pcg_pkg::*;

  // Reference model state
  pcg_state_e               state;
  pcg_state_e               next_state;
  pcg_addr_t                exp_pc;
  logic                     pc_known;
  logic [PCG_ERR_CNT_W-1:0] exp_count;
  logic                     alarm_q;

  // Expectations of the row applied last cycle
  logic prev_valid;
  logic prev_err;
  logic prev_alarm;

  // Highest priority request wins, targets are halfword aligned
  function automatic pcg_addr_t event_target(input pcg_event_t ev, input pcg_targets_t t);
    pcg_addr_t addr;
    if (ev.trap) begin
      addr = t.mtvec;
    end else if (ev.mret) begin
      addr = t.mepc;
    end else if (ev.branch) begin
      addr = t.branch_target;
    end else begin
      addr = t.jump_target;
    end
    addr[0] = 1'b0;
    return addr;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s: dut 'h%0h, expected 'h%0h at %0t ns", name, got, exp, $time);
  endtask

  ////////////////////////////////////////
  // Compare mid cycle, then step the model
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      state         = ST_RESET;
      exp_pc        = '0;
      pc_known      = 1'b0;
      exp_count     = '0;
      alarm_q       = 1'b0;
      prev_valid    = 1'b0;
      prev_err      = 1'b0;
      prev_alarm    = 1'b0;
      pc_if_errs_o  = 0;
      pc_err_errs_o = 0;
      alarm_errs_o  = 0;
      count_errs_o  = 0;
    end else begin
      // PC only known once boot has loaded it
      if (pc_known && pc_if_i !== exp_pc) begin
        report_mismatch("pc_if_o", pc_if_i, exp_pc);
        pc_if_errs_o++;
      end
      if (err_count_i !== exp_count) begin
        report_mismatch("err_count_o", err_count_i, exp_count);
        count_errs_o++;
      end
      if (prev_valid) begin
        if (pc_err_i !== prev_err) begin
          report_mismatch("pc_err_o", pc_err_i, prev_err);
          pc_err_errs_o++;
        end
        if (alarm_i !== prev_alarm) begin
          report_mismatch("alarm_o", alarm_i, prev_alarm);
          alarm_errs_o++;
        end
      end

      // Effect of the coming rising edge, mask applies to every load
      next_state = state;
      case (state)
        ST_RESET: begin
          next_state = ST_BOOT;
        end
        ST_BOOT: begin
          exp_pc     = {targets_i.boot_addr[31:1], 1'b0} ^ fault_mask_i;
          pc_known   = 1'b1;
          next_state = ST_RUN;
        end
        ST_RUN: begin
          if (event_i != 4'b0000) begin
            exp_pc = event_target(event_i, targets_i) ^ fault_mask_i;
          end else begin
            exp_pc = (exp_pc + (compressed_i ? 32'd2 : 32'd4)) ^ fault_mask_i;
            if (halt_i) begin
              next_state = ST_HALT;
            end
          end
        end
        ST_HALT: begin
          if (!halt_i) begin
            next_state = ST_RUN;
          end
        end
        // Locked, nothing moves
        default: begin
          next_state = state;
        end
      endcase
      if (alarm_q) begin
        next_state = ST_LOCK;
      end
      state = next_state;

      // Count follows the expected error pulses, saturating
      if (prev_valid && prev_err && exp_count != '1) begin
        exp_count = exp_count + 1'b1;
      end
      if (exp_count >= PCG_ALARM_THRESHOLD) begin
        alarm_q = 1'b1;
      end

      prev_valid = row_valid_i;
      prev_err   = exp_pc_err_i;
      prev_alarm = exp_alarm_i;
    end
  end

endmodule

//--- test/tb_pcg_top.sv
`timescale 1ns/1ps

module tb_pcg_top;
  import pcg_pkg::*;

  localparam int CLK_PERIOD_NS = 100;

  // Requests, trap mret branch jump from MSB down
  localparam pcg_event_t EV_NONE   = 4'b0000;
  localparam pcg_event_t EV_JUMP   = 4'b0001;
  localparam pcg_event_t EV_BRANCH = 4'b0010;
  localparam pcg_event_t EV_MRET   = 4'b0100;
  localparam pcg_event_t EV_TRAP   = 4'b1000;

  // Stimulus row, expectations hold for the cycle after the row
  typedef struct packed {
    pcg_event_t   ev;
    logic         halt;
    logic         compressed;
    pcg_addr_t    fault_mask;
    pcg_targets_t targets;
    logic         exp_pc_err;
    logic         exp_alarm;
  } row_t;

  row_t         rows[$];
  pcg_targets_t rand_targets;
  integer       seed;
  logic         table_ready = 1'b0;

  logic                     clk;
  logic                     rst_n;
  pcg_event_t               ev;
  pcg_targets_t             targets;
  logic                     compressed;
  logic                     halt;
  pcg_addr_t                fault_mask;
  pcg_addr_t                pc_if;
  logic                     pc_err;
  logic                     alarm;
  logic [PCG_ERR_CNT_W-1:0] err_count;
  logic                     row_valid;
  logic                     exp_pc_err;
  logic                     exp_alarm;

  int unsigned pc_if_errs;
  int unsigned pc_err_errs;
  int unsigned alarm_errs;
  int unsigned count_errs;
  int unsigned assert_errs;
  int unsigned total_errs;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  pcg_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .event_i      (ev),
    .targets_i    (targets),
    .compressed_i (compressed),
    .halt_i       (halt),
    .fault_mask_i (fault_mask),
    .pc_if_o      (pc_if),
    .pc_err_o     (pc_err),
    .alarm_o      (alarm),
    .err_count_o  (err_count)
  );

  tb_pcg_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .event_i       (ev),
    .targets_i     (targets),
    .compressed_i  (compressed),
    .halt_i        (halt),
    .fault_mask_i  (fault_mask),
    .pc_if_i       (pc_if),
    .pc_err_i      (pc_err),
    .alarm_i       (alarm),
    .err_count_i   (err_count),
    .row_valid_i   (row_valid),
    .exp_pc_err_i  (exp_pc_err),
    .exp_alarm_i   (exp_alarm),
    .pc_if_errs_o  (pc_if_errs),
    .pc_err_errs_o (pc_err_errs),
    .alarm_errs_o  (alarm_errs),
    .count_errs_o  (count_errs)
  );

  // FSM state comes from the sibling controller
  bind pcg_pc_check pcg_pc_check_assert u_pc_check_assert (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_i           (ctrl_i),
    .pc_err_i         (pc_err_o),
    .compare_enable_i (compare_enable_q),
    .state_i          (tb_pcg_top.dut.u_ctrl_fsm.state_q)
  );

  task automatic add_row(input pcg_event_t r_ev, input logic r_halt, input logic r_comp,
                         input pcg_addr_t r_mask, input logic r_err, input logic r_alarm);
    row_t row;
    row.ev         = r_ev;
    row.halt       = r_halt;
    row.compressed = r_comp;
    row.fault_mask = r_mask;
    row.targets    = rand_targets;
    row.exp_pc_err = r_err;
    row.exp_alarm  = r_alarm;
    rows.push_back(row);
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  task automatic build_table();
    // Boot cycle, then mixed sizes
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
    // Each target on its own
    add_row(EV_JUMP, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
    add_row(EV_BRANCH, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_TRAP, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_MRET, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    // Priority with several requests at once
    add_row(EV_BRANCH | EV_JUMP, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_MRET | EV_BRANCH | EV_JUMP, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_TRAP | EV_MRET | EV_BRANCH | EV_JUMP, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
    // Halt, the first row still advances, a jump inside is dropped
    add_row(EV_NONE, 1'b1, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b1, 1'b1, 32'h0, 1'b0, 1'b0);
    add_row(EV_JUMP, 1'b1, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    // Faults on an advance and on a target load
    add_row(EV_NONE, 1'b0, 1'b1, 32'h0000_0100, 1'b1, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    add_row(EV_JUMP, 1'b0, 1'b0, 32'h0000_0010, 1'b1, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
    // Third fault trips the alarm
    add_row(EV_NONE, 1'b0, 1'b1, 32'h0000_0004, 1'b1, 1'b0);
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
    add_row(EV_NONE, 1'b0, 1'b1, 32'h0, 1'b0, 1'b1);
    // Locked, requests and mask have no effect
    add_row(EV_TRAP, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
    add_row(EV_JUMP, 1'b0, 1'b0, 32'hffff_0000, 1'b0, 1'b1);
    add_row(EV_NONE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
  endtask

  task automatic apply_row(input row_t row);
    ev         <= row.ev;
    halt       <= row.halt;
    compressed <= row.compressed;
    fault_mask <= row.fault_mask;
    targets    <= row.targets;
    exp_pc_err <= row.exp_pc_err;
    exp_alarm  <= row.exp_alarm;
    row_valid  <= 1'b1;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    seed = 32'hfbc7_f232;
    rand_targets.boot_addr     = $random(seed);
    rand_targets.jump_target   = $random(seed);
    rand_targets.branch_target = $random(seed);
    rand_targets.mtvec         = $random(seed);
    rand_targets.mepc          = $random(seed);
    build_table();

    // Idle inputs until the first row
    ev          = EV_NONE;
    targets     = rand_targets;
    compressed  = 1'b0;
    halt        = 1'b0;
    fault_mask  = '0;
    row_valid   = 1'b0;
    exp_pc_err  = 1'b0;
    exp_alarm   = 1'b0;
    table_ready = 1'b1;

    // First row lands in the boot cycle
    @(posedge rst_n);
    foreach (rows[i]) begin
      @(posedge clk);
      apply_row(rows[i]);
    end

    // One more cycle so the last row gets checked
    @(posedge clk);
    row_valid  <= 1'b0;
    ev         <= EV_NONE;
    fault_mask <= '0;
    @(posedge clk);

    assert_errs = dut.u_pc_check.u_pc_check_assert.fail_cnt;
    total_errs  = pc_if_errs + pc_err_errs + alarm_errs + count_errs + assert_errs;
    $display("errors: pc_if %0d, pc_err %0d, alarm %0d, err_count %0d, assertions %0d",
             pc_if_errs, pc_err_errs, alarm_errs, count_errs, assert_errs);
    if (total_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog, table length plus margin for reset and drain
  initial begin
    wait (table_ready);
    #((rows.size() + 10) * CLK_PERIOD_NS);
    $display("timeout: the stimulus table did not finish in time");
    $display("sim failed");
    $finish;
  end

endmodule
